// File: src/fetch_consts.svh
/*
 * sizes shared by the fetch front end
 * word width, lane count and instruction cache geometry
 */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and instruction word width
`define XLEN 32

// instructions fetched per cycle
`define FETCH_WIDTH 3

// direct mapped with one block per line
`define ICACHE_LINES 16
`define BLOCK_BITS 64

`endif

// File: src/fetch_pkg.sv
/*
 * fetch front end types
 * dispatch packet, memory port structs, cache fill and miss FSM states
 */
`include "fetch_consts.svh"

package fetch_pkg;

    // one lane handed from fetch to dispatch
    typedef struct packed {
        logic             valid; // low means the rest is garbage
        logic [`XLEN-1:0] inst;
        logic [`XLEN-1:0] npc;   // pc + 4
        logic [`XLEN-1:0] pc;
    } if_id_packet;

    // request side of the four-phase memory link
    typedef struct packed {
        logic             req;
        logic [`XLEN-4:0] block_addr; // address bits 31:3
    } imem_req;

    // response side with data valid while ack is high
    typedef struct packed {
        logic                   ack;
        logic [`BLOCK_BITS-1:0] data;
    } imem_rsp;

    // one line write into the icache
    typedef struct packed {
        logic                   en;
        logic [`XLEN-4:0]       block_addr;
        logic [`BLOCK_BITS-1:0] data;
    } icache_fill;

    typedef enum logic [1:0] {
        MISS_IDLE, // looking for a missing lane
        MISS_REQ,  // req high until ack
        MISS_DROP  // req low until ack falls
    } miss_state_t;

endpackage

// File: src/icache.sv
/*
 * direct mapped instruction cache
 * three combinational read lanes and one synchronous fill port
 */
`include "fetch_consts.svh"

module icache
    import fetch_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  logic [`FETCH_WIDTH-1:0][`XLEN-1:0] lane_pc,
    input  icache_fill                         fill,
    output logic [`FETCH_WIDTH-1:0]            lane_hit,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0] lane_inst
);

    localparam int INDEX_BITS = $clog2(`ICACHE_LINES); // pc bits 6:3
    localparam int TAG_BITS   = `XLEN - 3 - INDEX_BITS;  // pc bits 31:7

    logic [`BLOCK_BITS-1:0]    data_mem [`ICACHE_LINES];
    logic [TAG_BITS-1:0]       tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]  line_valid;

    logic [`FETCH_WIDTH-1:0][INDEX_BITS-1:0]  lane_index;
    logic [`FETCH_WIDTH-1:0][TAG_BITS-1:0]    lane_tag;
    logic [`FETCH_WIDTH-1:0][`BLOCK_BITS-1:0] lane_block;

    logic [INDEX_BITS-1:0] fill_index;
    logic [TAG_BITS-1:0]   fill_tag;

    // fill address is already block aligned, so the index sits at the bottom
    assign fill_index = fill.block_addr[INDEX_BITS-1:0];
    assign fill_tag   = fill.block_addr[`XLEN-4:INDEX_BITS];

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_index[i] = lane_pc[i][INDEX_BITS+2:3];
            lane_tag[i]   = lane_pc[i][`XLEN-1:INDEX_BITS+3];
            lane_block[i] = data_mem[lane_index[i]];
            lane_hit[i]   = line_valid[lane_index[i]] && (tag_mem[lane_index[i]] == lane_tag[i]);
            // pc bit 2 picks the word inside the block
            if (lane_pc[i][2]) begin
                lane_inst[i] = lane_block[i][`XLEN +: `XLEN]; // upper word
            end else begin
                lane_inst[i] = lane_block[i][0 +: `XLEN];
            end
        end
    end

    // data and tag written by the fill
    always_ff @(posedge clock) begin
        if (fill.en) begin
            data_mem[fill_index] <= fill.data;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0; // cold cache
        end else if (fill.en) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // the miss controller must stay quiet through reset and the cycle after
    a_no_fill_in_reset: assert property (
        @(posedge clock) reset |=> !fill.en
    ) else $error("icache fill during reset");

endmodule

// File: src/icache_miss_ctrl.sv
/*
 * icache miss controller
 * picks the oldest missing lane, runs the req/ack handshake, issues the fill
 */
`include "fetch_consts.svh"

module icache_miss_ctrl
    import fetch_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  logic [`FETCH_WIDTH-1:0][`XLEN-1:0] lane_pc,
    input  logic [`FETCH_WIDTH-1:0]            lane_hit,
    input  imem_rsp                            mem_rsp,
    output imem_req                            mem_req,
    output icache_fill                         fill
);

    miss_state_t state, state_next;

    logic                   any_miss;
    logic [`XLEN-4:0]       miss_addr;   // block of the oldest missing lane
    logic [`XLEN-4:0]       blk_addr_q;  // held for the whole transaction
    logic [`BLOCK_BITS-1:0] fill_data_q;
    logic                   fill_en_q;

    // lane 0 is youngest, so the last missing lane in the loop wins
    always_comb begin
        any_miss  = ~&lane_hit;
        miss_addr = lane_pc[0][`XLEN-1:3];
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!lane_hit[i]) begin
                miss_addr = lane_pc[i][`XLEN-1:3];
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            MISS_IDLE: if (any_miss && !mem_rsp.ack) state_next = MISS_REQ;
            MISS_REQ:  if (mem_rsp.ack) state_next = MISS_DROP;  // data captured here
            MISS_DROP: if (!mem_rsp.ack) state_next = MISS_IDLE; // handshake closed
            default:   state_next = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= MISS_IDLE;
            fill_en_q <= 1'b0;
        end else begin
            state     <= state_next;
            fill_en_q <= (state == MISS_REQ) && mem_rsp.ack; // one cycle pulse
        end
    end

    // payload registers
    always_ff @(posedge clock) begin
        if (state == MISS_IDLE && state_next == MISS_REQ) begin
            blk_addr_q <= miss_addr;
        end
        if (state == MISS_REQ && mem_rsp.ack) begin
            fill_data_q <= mem_rsp.data;
        end
    end

    assign mem_req.req        = (state == MISS_REQ);
    assign mem_req.block_addr = blk_addr_q;

    // written even when a branch has moved the pcs elsewhere
    assign fill.en         = fill_en_q;
    assign fill.block_addr = blk_addr_q;
    assign fill.data       = fill_data_q;

    a_addr_stable: assert property (
        @(posedge clock) disable iff (reset)
        (mem_req.req && !mem_rsp.ack) |=> $stable(mem_req.block_addr)
    ) else $error("block_addr changed while waiting for ack");

    a_req_after_ack_low: assert property (
        @(posedge clock) disable iff (reset) $rose(mem_req.req) |-> !mem_rsp.ack
    ) else $error("req raised while ack still high");

endmodule

// File: src/fetch_stage.sv
/*
 * fetch stage with three pc slots and next pc selection
 * in-order valid chain and dispatch packet assembly
 */
`include "fetch_consts.svh"

module fetch_stage
    import fetch_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                take_branch,
    input  logic [`XLEN-1:0]                    target_pc,      // used when take_branch is high
    input  logic                                dispatch_stall, // hold the pcs
    input  logic [`FETCH_WIDTH-1:0]             lane_hit,
    input  logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  lane_inst,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  lane_pc,
    output if_id_packet [`FETCH_WIDTH-1:0]      if_packet_out
);

    localparam int OLDEST = `FETCH_WIDTH - 1;

    logic [`FETCH_WIDTH-1:0][`XLEN-1:0] pc_slot;  // highest lane holds the oldest pc
    logic [`FETCH_WIDTH-1:0][`XLEN-1:0] pc_next;
    logic [`FETCH_WIDTH-1:0]            lane_valid;
    logic [`XLEN-1:0]                   oldest_next;

    assign lane_pc = pc_slot;

    // a lane counts only if every older lane is valid too
    always_comb begin
        lane_valid[OLDEST] = lane_hit[OLDEST];
        for (int i = OLDEST - 1; i >= 0; i--) begin
            lane_valid[i] = lane_hit[i] & lane_valid[i+1];
        end
    end

    always_comb begin
        // all lanes valid means continue past the youngest
        oldest_next = pc_slot[0] + `XLEN'(4);
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!lane_valid[i]) begin
                oldest_next = pc_slot[i]; // oldest not ready lane ends up here
            end
        end
        if (take_branch) begin
            oldest_next = target_pc;
        end else if (dispatch_stall) begin
            oldest_next = pc_slot[OLDEST];
        end
        pc_next[OLDEST] = oldest_next;
        for (int i = OLDEST - 1; i >= 0; i--) begin
            pc_next[i] = pc_next[i+1] + `XLEN'(4); // younger lanes follow sequentially
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                pc_slot[i] <= `XLEN'((OLDEST - i) * 4); // 0, 4, 8 from oldest down
            end
        end else begin
            pc_slot <= pc_next;
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if_packet_out[i].valid = lane_valid[i];
            if_packet_out[i].inst  = lane_valid[i] ? lane_inst[i] : '0;
            if_packet_out[i].npc   = pc_slot[i] + `XLEN'(4);
            if_packet_out[i].pc    = pc_slot[i];
        end
    end

    // misaligned target would break the half select in the cache
    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : g_align
        a_pc_aligned: assert property (
            @(posedge clock) disable iff (reset) pc_slot[g][1:0] == 2'b00
        ) else $error("lane %0d pc not word aligned", g);
    end

endmodule

// File: src/fetch_top.sv
/*
 * fetch front end top
 * fetch stage, icache and miss controller
 */
`include "fetch_consts.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           take_branch,
    input  logic [`XLEN-1:0]               target_pc,
    input  logic                           dispatch_stall,
    input  imem_rsp                        mem_rsp,
    output imem_req                        mem_req,
    output if_id_packet [`FETCH_WIDTH-1:0] if_packet_out
);

    logic [`FETCH_WIDTH-1:0][`XLEN-1:0] lane_pc;
    logic [`FETCH_WIDTH-1:0]            lane_hit;
    logic [`FETCH_WIDTH-1:0][`XLEN-1:0] lane_inst;
    icache_fill                         fill;  // miss controller into cache

    fetch_stage i_fetch_stage (
        .clock, .reset, .take_branch, .target_pc, .dispatch_stall,
        .lane_hit, .lane_inst, .lane_pc, .if_packet_out
    );

    icache i_icache (
        .clock, .reset, .lane_pc, .fill, .lane_hit, .lane_inst
    );

    // shares the lane pcs and hit vector with the cache lookup
    icache_miss_ctrl i_miss_ctrl (
        .clock, .reset, .lane_pc, .lane_hit,
        .mem_rsp, .mem_req, .fill
    );

endmodule

// File: dv/fetch_mem_model.sv
/*
 * testbench memory behind the four-phase req/ack port
 * LCG-random ack delays, block words follow a fixed hash of the byte address
 */
`include "fetch_consts.svh"

module fetch_mem_model
    import fetch_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  imem_req mem_req,
    output imem_rsp mem_rsp
);

    logic [31:0] lcg_state;

    // classic 32-bit LCG with the delay taken from the middle bits
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return 1 + (int'(lcg_state[30:16]) % 6); // 1 to 6 cycles
    endfunction

    // 32'h9e3779b1 is 2654435761
    function automatic logic [`XLEN-1:0] word_at(logic [`XLEN-1:0] addr);
        return addr * 32'h9e3779b1 + 32'd19;
    endfunction

    function automatic logic [`BLOCK_BITS-1:0] block_at(logic [`XLEN-4:0] block_addr);
        logic [`XLEN-1:0] addr;
        addr = {block_addr, 3'b000};
        return {word_at(addr + 32'd4), word_at(addr)}; // lower word at the lower address
    endfunction

    initial begin
        int delay;
        lcg_state = 32'd32045;
        mem_rsp   = '0;
        forever begin
            @(negedge clock);
            if (!reset && mem_req.req) begin
                delay = next_delay();
                repeat (delay) @(negedge clock);
                mem_rsp.data = block_at(mem_req.block_addr);
                mem_rsp.ack  = 1'b1;  // data valid with ack
                @(negedge clock);
                while (mem_req.req) @(negedge clock); // controller drops req once it saw ack
                delay = next_delay();
                repeat (delay) @(negedge clock);
                mem_rsp.ack = 1'b0;
            end
        end
    end

endmodule

// File: dv/fetch_tb.sv
/*
 * fetch front end testbench
 * clock, reset, command reader, scoreboard, watchdog and report
 */
`include "fetch_consts.svh"

module fetch_tb
    import fetch_pkg::*;
();

    logic                           clock;
    logic                           reset;
    logic                           take_branch;
    logic [`XLEN-1:0]               target_pc;
    logic                           dispatch_stall;
    imem_req                        mem_req;
    imem_rsp                        mem_rsp;
    if_id_packet [`FETCH_WIDTH-1:0] if_packet_out;

    string       cmd_op[$];
    int unsigned cmd_arg[$];
    bit          loaded;
    logic [31:0] expected_pc; // next pc dispatch should see
    int          consumed;
    int          checks;
    int          errors;
    string       test_name;

    fetch_top i_dut (
        .clock, .reset, .take_branch, .target_pc, .dispatch_stall,
        .mem_rsp, .mem_req, .if_packet_out
    );

    fetch_mem_model i_mem (.clock, .reset, .mem_req, .mem_rsp);

    always #10 clock = ~clock;

    // word at byte address a is a * 2654435761 + 19
    function automatic logic [31:0] expected_word(logic [31:0] addr);
        return addr * 32'h9e3779b1 + 32'd19;
    endfunction

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // check and consume one cycle's outputs, then drive that cycle's inputs
    task automatic step(input bit stall, input bit branch, input logic [31:0] target);
        bit in_order;
        in_order = 1'b1;
        @(negedge clock); // outputs settled since the rising edge
        for (int i = 0; i < `FETCH_WIDTH - 1; i++) begin
            checks++;
            assert (!if_packet_out[i].valid || if_packet_out[i+1].valid) else begin
                errors++;
                $display("%s: lane %0d is valid behind an invalid older lane", test_name, i);
            end
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!if_packet_out[i].valid) begin
                check_value("idle inst", '0, if_packet_out[i].inst); // no word on an idle lane
            end
        end
        check_value("oldest pc", expected_pc, if_packet_out[`FETCH_WIDTH-1].pc);
        if (!stall && !branch) begin
            for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
                if (in_order && if_packet_out[i].valid) begin
                    check_value("pc", expected_pc, if_packet_out[i].pc);
                    check_value("npc", expected_pc + 32'd4, if_packet_out[i].npc);
                    check_value("inst", expected_word(expected_pc), if_packet_out[i].inst);
                    expected_pc = expected_pc + 32'd4;
                    consumed++;
                end else begin
                    in_order = 1'b0;
                end
            end
        end
        dispatch_stall = stall;
        take_branch    = branch;
        target_pc      = target;
    endtask

    task automatic load_commands(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       op;
        int unsigned arg;
        ok = 1'b0;
        fd = $fopen("dv/fetch_input.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s", op);
                    if (op == "branch") begin
                        n = $sscanf(line, "%s %h", op, arg); // target in hex
                    end else begin
                        n = $sscanf(line, "%s %d", op, arg);
                    end
                    cmd_op.push_back(op);
                    cmd_arg.push_back(arg);
                end
            end
            $fclose(fd);
        end
    endtask

    // 200 cycles per command plus the reset
    initial begin
        wait (loaded);
        repeat (16 + 200 * cmd_op.size()) @(posedge clock);
        $display("timeout: commands did not finish within %0d cycles", 200 * cmd_op.size());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit ok;
        int start_errors;
        clock = 1'b0;
        reset = 1'b1;
        take_branch = 1'b0;
        target_pc = '0;
        dispatch_stall = 1'b0;
        expected_pc = '0;
        checks = 0;
        errors = 0;
        load_commands(ok);
        if (!ok) begin
            $display("cannot open dv/fetch_input.txt");
        end else begin
            loaded = 1'b1;
            repeat (16) @(negedge clock);
            reset = 1'b0;
            for (int c = 0; c < cmd_op.size(); c++) begin
                test_name = $sformatf("cmd%0d %s %0h", c, cmd_op[c], cmd_arg[c]);
                start_errors = errors;
                if (cmd_op[c] == "run") begin
                    consumed = 0;
                    while (consumed < cmd_arg[c]) step(1'b0, 1'b0, '0); // a cycle may overshoot N
                end else if (cmd_op[c] == "branch") begin
                    step(1'b0, 1'b1, cmd_arg[c]);
                    expected_pc = cmd_arg[c];
                end else if (cmd_op[c] == "stall") begin
                    repeat (cmd_arg[c]) step(1'b1, 1'b0, '0);
                end else begin
                    errors++;
                    $display("%s: unknown command in the input file", test_name);
                end
                $display("%s: %s, %0d errors", test_name,
                         (errors == start_errors) ? "ok" : "failed", errors - start_errors);
            end
            $display("commands %0d, checks %0d, errors %0d", cmd_op.size(), checks, errors);
        end
        if (ok && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/fetch_input.txt
# columns: command, argument
# run <packets, decimal>   branch <target pc, hex>   stall <cycles, decimal>
# sequential stream from pc 0 through cold misses
run 16
# back to 0, these blocks now sit in the cache
branch 00000000
run 16
stall 3
run 4
# target with address bit 2 set
branch 00000104
run 9
stall 5
run 12
stall 1
run 3
# second branch arrives while the miss for the first is in flight
branch 0000020c
stall 2
branch 00000044
run 15

// File: sim.f
+incdir+src
src/fetch_pkg.sv
src/icache.sv
src/icache_miss_ctrl.sv
src/fetch_stage.sv
src/fetch_top.sv
dv/fetch_mem_model.sv
dv/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -Mdir obj_dir -o fetch_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
